// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;                    // data and address width
    localparam int imem_addr_bits = 8;           // 256 instruction words
    localparam int dmem_addr_bits = 8;           // 256 data words
    localparam logic [xlen-1:0] reset_pc = '0;

    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011                  // ecall, ebreak, csr
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_copy_b                               // lui passes imm through
    } alu_op_e;

    // matches branch funct3, 010 is free for none
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_none = 3'b010,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        wb_none, wb_pc_plus4, wb_alu, wb_mem
    } wb_sel_e;

    typedef enum logic [2:0] {
        size_byte   = 3'b000,
        size_half   = 3'b001,
        size_word   = 3'b010,
        size_byte_u = 3'b100,
        size_half_u = 3'b101
    } mem_size_e;

endpackage

// ==== rtl/rv_ctrl_if.sv ====
`timescale 1ns/100ps

interface rv_ctrl_if;
    import rv_pkg::*;

    logic            a_sel_pc;   // operand a is pc, not rs1
    logic            b_sel_imm;  // operand b is imm, not rs2
    alu_op_e         alu_op;
    branch_e         branch;
    logic            is_jump;    // jal or jalr
    wb_sel_e         wb_sel;
    logic            reg_we;
    logic            mem_rd;
    logic            mem_wr;
    mem_size_e       mem_size;
    logic [xlen-1:0] imm;

    modport decoder (
        output a_sel_pc, b_sel_imm, alu_op, branch, is_jump, wb_sel,
               reg_we, mem_rd, mem_wr, mem_size, imm
    );

    modport consumer (
        input a_sel_pc, b_sel_imm, alu_op, branch, is_jump, wb_sel,
              reg_we, mem_rd, mem_wr, mem_size, imm
    );
endinterface

// ==== rtl/rv_fetch.sv ====
`timescale 1ns/100ps

module rv_fetch (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              run,
    input  logic                              load_en,
    input  logic [rv_pkg::imem_addr_bits-1:0] load_addr,
    input  logic [rv_pkg::xlen-1:0]           load_data,
    input  logic                              jump_en,
    input  logic [rv_pkg::xlen-1:0]           jump_pc,
    output logic [rv_pkg::xlen-1:0]           pc,
    output logic [rv_pkg::xlen-1:0]           inst
);
    import rv_pkg::*;

    logic [xlen-1:0] imem [0:2**imem_addr_bits-1];
    logic [xlen-1:0] next_pc;

    // jalr target may be odd, drop bit 0
    assign next_pc = jump_en ? {jump_pc[xlen-1:1], 1'b0} : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (run) begin
            pc <= next_pc;
        end else begin
            pc <= reset_pc;  // park until run
        end
    end

    // program loading only while halted
    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    assign inst = imem[pc[imem_addr_bits+1:2]];  // word addressed

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    rv_ctrl_if.decoder              ctrl
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // shared by op and op_imm, alt is funct7 bit 5
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl.a_sel_pc  = 1'b0;      // defaults form a nop
        ctrl.b_sel_imm = 1'b0;
        ctrl.alu_op    = alu_add;
        ctrl.branch    = br_none;
        ctrl.is_jump   = 1'b0;
        ctrl.wb_sel    = wb_none;
        ctrl.reg_we    = 1'b0;
        ctrl.mem_rd    = 1'b0;
        ctrl.mem_wr    = 1'b0;
        ctrl.mem_size  = size_word;
        ctrl.imm       = '0;
        case (opcode)
            opc_op: begin
                ctrl.alu_op = alu_from_funct3(funct3, inst[30]);
                ctrl.wb_sel = wb_alu;
                ctrl.reg_we = 1'b1;
            end
            opc_op_imm: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && inst[30]);
                ctrl.wb_sel    = wb_alu;
                ctrl.reg_we    = 1'b1;
                ctrl.imm       = imm_i;
            end
            opc_lui: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = alu_copy_b;
                ctrl.wb_sel    = wb_alu;
                ctrl.reg_we    = 1'b1;
                ctrl.imm       = imm_u;
            end
            opc_auipc: begin
                ctrl.a_sel_pc  = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = wb_alu;
                ctrl.reg_we    = 1'b1;
                ctrl.imm       = imm_u;
            end
            opc_jal, opc_jalr: begin
                ctrl.a_sel_pc  = (opcode == opc_jal);  // jalr adds to rs1
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
                ctrl.reg_we    = 1'b1;
                ctrl.imm       = (opcode == opc_jal) ? imm_j : imm_i;
            end
            opc_branch: begin
                ctrl.a_sel_pc  = 1'b1;  // alu forms the target
                ctrl.b_sel_imm = 1'b1;
                ctrl.branch    = (funct3[2:1] == 2'b01) ? br_none : branch_e'(funct3);
                ctrl.imm       = imm_b;
            end
            opc_load: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = wb_mem;
                ctrl.reg_we    = 1'b1;
                ctrl.mem_rd    = 1'b1;
                ctrl.mem_size  = mem_size_e'(funct3);
                ctrl.imm       = imm_i;
            end
            opc_store: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_wr    = 1'b1;
                ctrl.mem_size  = mem_size_e'(funct3);
                ctrl.imm       = imm_s;
            end
            opc_system: ctrl.reg_we = 1'b0;     // ecall, ebreak, csr ignored
            default:    ctrl.reg_we = 1'b0;     // fence and unknown
        endcase
    end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    run,
    rv_ctrl_if.consumer             ctrl,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::xlen-1:0] wd,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (run && ctrl.reg_we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= wd;
        end
    end

    // x0 reads as zero, its storage is never written
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
    rv_ctrl_if.consumer             ctrl,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] mem_rd_data,
    output logic [rv_pkg::xlen-1:0] alu_out,
    output logic                    jump_en,
    output logic [rv_pkg::xlen-1:0] wb_data
);
    import rv_pkg::*;

    logic [xlen-1:0] alu_a, alu_b;
    logic            taken;

    assign alu_a = ctrl.a_sel_pc ? pc : rs1_data;
    assign alu_b = ctrl.b_sel_imm ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_out = alu_a - alu_b;
            alu_sll:    alu_out = alu_a << alu_b[4:0];
            alu_slt:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu:   alu_out = {31'b0, alu_a < alu_b};
            alu_xor:    alu_out = alu_a ^ alu_b;
            alu_srl:    alu_out = alu_a >> alu_b[4:0];
            alu_sra:    alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            alu_or:     alu_out = alu_a | alu_b;
            alu_and:    alu_out = alu_a & alu_b;
            alu_copy_b: alu_out = alu_b;
            default:    alu_out = alu_a + alu_b;  // add, also addresses and targets
        endcase
    end

    // compare always on the registers, alu is busy with the target
    always_comb begin
        case (ctrl.branch)
            br_beq:  taken = (rs1_data == rs2_data);
            br_bne:  taken = (rs1_data != rs2_data);
            br_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            br_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            br_bltu: taken = (rs1_data < rs2_data);
            br_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign jump_en = ctrl.is_jump || taken;

    always_comb begin
        case (ctrl.wb_sel)
            wb_pc_plus4: wb_data = pc + 32'd4;  // link address
            wb_alu:      wb_data = alu_out;
            wb_mem:      wb_data = mem_rd_data;
            default:     wb_data = '0;
        endcase
    end

endmodule

// ==== rtl/rv_data_mem.sv ====
`timescale 1ns/100ps

module rv_data_mem (
    input  logic                    clk,
    input  logic                    run,
    rv_ctrl_if.consumer             ctrl,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wr_data,
    output logic [rv_pkg::xlen-1:0] rd_data
);
    import rv_pkg::*;

    logic [xlen-1:0]           dmem [0:2**dmem_addr_bits-1];
    logic [dmem_addr_bits-1:0] idx;
    logic [xlen-1:0]           word, lane_data;
    logic [7:0]                byte_val;
    logic [15:0]               half_val;
    logic [3:0]                be;

    assign idx      = addr[dmem_addr_bits+1:2];  // low bits pick the lane
    assign word     = dmem[idx];
    assign byte_val = word[8*addr[1:0] +: 8];
    assign half_val = word[16*addr[1] +: 16];

    always_comb begin
        case (ctrl.mem_size)
            size_byte:   rd_data = {{24{byte_val[7]}}, byte_val};
            size_half:   rd_data = {{16{half_val[15]}}, half_val};
            size_byte_u: rd_data = {24'b0, byte_val};
            size_half_u: rd_data = {16'b0, half_val};
            default:     rd_data = word;
        endcase
        if (!ctrl.mem_rd) rd_data = '0;
    end

    // store lanes, data replicated so every lane sees its part
    always_comb begin
        case (ctrl.mem_size)
            size_byte: begin
                be        = 4'b0001 << addr[1:0];
                lane_data = {4{wr_data[7:0]}};
            end
            size_half: begin
                be        = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wr_data[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = wr_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (run && ctrl.mem_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) dmem[idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load_en,
    input  logic [rv_pkg::imem_addr_bits-1:0] load_addr,
    input  logic [rv_pkg::xlen-1:0]           load_data,
    input  logic                              run,
    output logic                              retire_valid,
    output logic [rv_pkg::xlen-1:0]           retire_pc,
    output logic [rv_pkg::xlen-1:0]           retire_inst,
    output logic [4:0]                        retire_rd,
    output logic [rv_pkg::xlen-1:0]           retire_data
);
    import rv_pkg::*;

    logic [xlen-1:0] pc, inst;
    logic [xlen-1:0] rs1_data, rs2_data;
    logic [xlen-1:0] alu_out, mem_rd_data, wb_data;
    logic            jump_en;

    rv_ctrl_if ctrl_if ();

    rv_fetch fetch_i (
        .clk(clk), .reset(reset), .run(run),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .jump_en(jump_en), .jump_pc(alu_out), .pc(pc), .inst(inst)
    );

    rv_decoder decoder_i (.inst(inst), .ctrl(ctrl_if.decoder));

    rv_regfile regfile_i (
        .clk(clk), .run(run), .ctrl(ctrl_if.consumer),
        .rs1_addr(inst[19:15]), .rs2_addr(inst[24:20]), .rd_addr(inst[11:7]),
        .wd(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_execute execute_i (
        .ctrl(ctrl_if.consumer), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .mem_rd_data(mem_rd_data), .alu_out(alu_out), .jump_en(jump_en), .wb_data(wb_data)
    );

    rv_data_mem data_mem_i (
        .clk(clk), .run(run), .ctrl(ctrl_if.consumer),
        .addr(alu_out), .wr_data(rs2_data), .rd_data(mem_rd_data)
    );

    // retire shows the write about to land at the next edge
    assign retire_valid = run && ctrl_if.reg_we && (inst[11:7] != 5'd0);
    assign retire_pc    = pc;
    assign retire_inst  = inst;
    assign retire_rd    = inst[11:7];
    assign retire_data  = wb_data;

endmodule

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;
    import rv_pkg::*;

    logic                      clk;
    logic                      reset;
    logic                      load_en;
    logic [imem_addr_bits-1:0] load_addr;
    logic [xlen-1:0]           load_data;
    logic                      run;
    logic                      retire_valid;
    logic [xlen-1:0]           retire_pc;
    logic [xlen-1:0]           retire_inst;
    logic [4:0]                retire_rd;
    logic [xlen-1:0]           retire_data;

    logic [31:0] file_words [0:255];  // header, program, expected writes
    int          prog_len, exp_count, exp_base;
    int          next_exp, cycles, limit;
    int          errors, test_errors, test_writes, tests_run, tests_failed;
    bit          timed_out;

    rv_core rv_core_i (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .run(run), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_inst(retire_inst), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] file_word(input int idx);
        return file_words[idx[7:0]];
    endfunction

    task automatic report_test(input int num);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0d passed, %0d writes checked", num, test_writes);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d writes wrong", num, test_errors, test_writes);
        end
        test_errors = 0;
        test_writes = 0;
    endtask

    // compare one retired write with the next expected entry
    task automatic check_retire();
        int          base;
        bit          bad;
        logic [31:0] exp_test, exp_rd, exp_value, exp_pc, exp_inst;
        base      = exp_base + 4 * next_exp;
        exp_test  = file_word(base);
        exp_rd    = file_word(base + 1);
        exp_value = file_word(base + 2);
        exp_pc    = file_word(base + 3);
        exp_inst  = file_word(2 + exp_pc[imem_addr_bits+1:2]);  // program word at that pc
        bad       = 1'b0;
        if (retire_rd !== exp_rd[4:0] || retire_pc !== exp_pc) begin
            $display("[FAIL] %0d ns: test %0d expected x%0d at pc %h, got x%0d at pc %h",
                     $time, exp_test, exp_rd, exp_pc, retire_rd, retire_pc);
            bad = 1'b1;
        end
        if (retire_inst !== exp_inst) begin
            $display("[FAIL] %0d ns: test %0d expected inst %h at pc %h, got %h",
                     $time, exp_test, exp_inst, exp_pc, retire_inst);
            bad = 1'b1;
        end
        if (retire_data !== exp_value) begin
            $display("[FAIL] %0d ns: test %0d x%0d expected %h, got %h",
                     $time, exp_test, exp_rd, exp_value, retire_data);
            bad = 1'b1;
        end
        if (bad) test_errors++;
        test_writes++;
        next_exp++;
        if (next_exp == exp_count || file_word(base + 4) != exp_test) begin
            report_test(exp_test);  // last write of this test
        end
    endtask

    initial begin
        int i;
        reset     <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        run       <= 1'b0;
        $readmemh("tb/program_input.mem", file_words);
        prog_len  = file_word(0);
        exp_count = file_word(1);
        exp_base  = 2 + prog_len;
        limit     = 4 * exp_count + 200;  // cycles after run rises
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        if (prog_len == 0 || exp_count == 0) begin
            $display("no program or expected writes could be read from tb/program_input.mem");
            errors++;
        end else begin
            for (i = 0; i < prog_len; i++) begin
                @(posedge clk);
                load_en   <= 1'b1;
                load_addr <= imem_addr_bits'(i);
                load_data <= file_word(2 + i);
            end
            @(posedge clk);
            load_en <= 1'b0;
            run     <= 1'b1;
            while (next_exp < exp_count && cycles < limit) begin
                @(negedge clk);  // retire outputs settled mid cycle
                cycles++;
                if (retire_valid === 1'b1) check_retire();
            end
            if (next_exp < exp_count) begin
                $display("timeout: only %0d of %0d expected writes retired in %0d cycles",
                         next_exp, exp_count, limit);
                timed_out = 1'b1;
            end
        end
        $display("%0d tests run, %0d failed, %0d wrong writes", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
rtl/rv_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_data_mem.sv
rtl/rv_core.sv
tb/rv_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := rv_core_tb
FILELIST  := rv_core.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Regression passed

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation log has no pass line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/program_input.mem ====
// word 0 program length, word 1 expected write count, then the program words
// expected writes follow, four words each: test number, rd, value, pc
3c 21
00500093 ffd00113 002081b3 40208233 001122b3 00113333 00409393 01c15413 // alu
40115493 0ff0c513 0020e5b3 00012613
123456b7 00001717 fffff7b7                                              // lui, auipc
00208463 00108463 fff00813 00100893 00109463 00209463 fff00813 00200893 // beq, bne
0020c463 00114463 fff00813 00300893 00115463 0020d463 fff00813 00400893 // blt, bge
00116463 0020e463 fff00813 00500893 0020f463 00117463 fff00813 00600893 // bltu, bgeu
008009ef fff00813 0b000a13 005a0ae7 fff00813 fff00813 00700b13          // jal, jalr
87654bb7 321b8b93 11702023 10201123 101000a3 10002c03 10201c83 10205d03 // stores, loads
10300d83 10304e03
00900013 00208033 05500e93 0000006f                                     // x0, then spin
1 01 00000005 00  1 02 fffffffd 04  1 03 00000002 08
1 04 00000008 0c  1 05 00000001 10  1 06 00000000 14
1 07 00000050 18  1 08 0000000f 1c  1 09 fffffffe 20
1 0a 000000fa 24  1 0b fffffffd 28  1 0c 00000001 2c
2 0d 12345000 30  2 0e 00001034 34  2 0f fffff000 38
3 11 00000001 48  3 11 00000002 58  3 11 00000003 68  // only the target addi retires
3 11 00000004 78  3 11 00000005 88  3 11 00000006 98
4 13 000000a0 9c  4 14 000000b0 a4  4 15 000000ac a8  4 16 00000007 b4
5 17 87654000 b8  5 17 87654321 bc  5 18 fffd0521 cc
5 19 fffffffd d0  5 1a 0000fffd d4  5 1b ffffffff d8
5 1c 000000ff dc
6 1d 00000055 e8
